// ==== hw/alu_cfg.svh ====
// Execute block configuration: data width and step count of the multiply/divide units
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Operand and result width of the integer datapath
`define ALU_XLEN 32

// One product or quotient bit per cycle
`define MULDIV_STEPS 32

`endif

// ==== hw/alu_op_pkg.sv ====
// ALU operation package: opcode encoding and the request/result structs of the execute block
`include "alu_cfg.svh"

package alu_op_pkg;

	typedef enum logic [5:0] {
		op_sll    = 6'b000000,
		op_srl    = 6'b000010,
		op_sra    = 6'b000011,
		op_sllv   = 6'b000100,
		op_srlv   = 6'b000110,
		op_srav   = 6'b000111,
		op_mfhi   = 6'b010000,
		op_mthi   = 6'b010001,
		op_mflo   = 6'b010010,
		op_mtlo   = 6'b010011,
		op_mult   = 6'b011000,
		op_multu  = 6'b011001,
		op_div    = 6'b011010,
		op_divu   = 6'b011011,
		op_add    = 6'b100000,
		op_addu   = 6'b100001,
		op_sub    = 6'b100010,
		op_subu   = 6'b100011,
		op_and    = 6'b100100,
		op_or     = 6'b100101,
		op_xor    = 6'b100110,
		op_nor    = 6'b100111,
		op_slt    = 6'b101010,
		op_sltu   = 6'b101011,
		op_lui    = 6'b101100,
		op_pass_a = 6'b111110,	// Operand a unchanged
		op_pass_b = 6'b111111	// Operand b unchanged
	} alu_op_e;

	typedef struct packed {
		alu_op_e              op;
		logic [`ALU_XLEN-1:0] a;	// Also carries shamt in [4:0]
		logic [`ALU_XLEN-1:0] b;
	} alu_req_t;

	typedef struct packed {
		logic [`ALU_XLEN-1:0] value;
		logic                 ovf;	// Trapping add/sub overflow
	} alu_res_t;

endpackage

// ==== hw/muldiv_pkg.sv ====
// Multiply/divide package: unit request and the HI/LO register pair
`include "alu_cfg.svh"

package muldiv_pkg;

	// Operands handed to the multiplier or divider at start
	typedef struct packed {
		logic [`ALU_XLEN-1:0] a;	// Multiplicand or dividend
		logic [`ALU_XLEN-1:0] b;	// Multiplier or divisor
		logic                 is_signed;
	} md_req_t;

	// Product halves, or remainder in hi and quotient in lo
	typedef struct packed {
		logic [`ALU_XLEN-1:0] hi;
		logic [`ALU_XLEN-1:0] lo;
	} hilo_t;

endpackage

// ==== hw/seq_multiplier.sv ====
// Sequential multiplier: shift-add over operand magnitudes, sign fix-up on the last step
`timescale 1ns/1ps
`include "alu_cfg.svh"

module seq_multiplier import muldiv_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    start,
	input  md_req_t req,
	output logic    busy,
	output logic    done,
	output hilo_t   result
);

	localparam int CNT_W = $clog2(`MULDIV_STEPS);

	logic [`ALU_XLEN-1:0]   mag_a;
	logic [`ALU_XLEN-1:0]   mag_b;
	logic [`ALU_XLEN-1:0]   mcand;		// Multiplicand magnitude
	logic [2*`ALU_XLEN-1:0] prod;		// Partial product over remaining multiplier bits
	logic                   neg;		// Product sign
	logic [CNT_W-1:0]       step_cnt;
	logic                   last_step;
	logic [`ALU_XLEN:0]     part_sum;	// Upper half plus carry
	logic [2*`ALU_XLEN-1:0] prod_next;

	assign mag_a = (req.is_signed && req.a[`ALU_XLEN-1]) ? -req.a : req.a;
	assign mag_b = (req.is_signed && req.b[`ALU_XLEN-1]) ? -req.b : req.b;

	// One add-and-shift step, driven by the multiplier bit in prod[0]
	assign part_sum  = {1'b0, prod[2*`ALU_XLEN-1:`ALU_XLEN]} + (prod[0] ? {1'b0, mcand} : '0);
	assign prod_next = {part_sum, prod[`ALU_XLEN-1:1]};

	assign last_step = (step_cnt == CNT_W'(`MULDIV_STEPS - 1));
	assign done      = busy && last_step;

	// Final step result with the sign applied, loaded by the core on done
	assign result = neg ? hilo_t'(-prod_next) : hilo_t'(prod_next);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			step_cnt <= '0;
		end else if (start) begin
			busy     <= 1'b1;
			step_cnt <= '0;
		end else if (busy) begin
			step_cnt <= step_cnt + 1'b1;
			if (last_step) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			mcand <= mag_a;
			prod  <= {{`ALU_XLEN{1'b0}}, mag_b};
			neg   <= req.is_signed && (req.a[`ALU_XLEN-1] ^ req.b[`ALU_XLEN-1]);
		end else if (busy) begin
			prod <= prod_next;
		end
	end

	// The issuer must wait for stall to drop before the next multiply
	a_no_start_while_busy: assert property (@(posedge clk) disable iff (rst)
		start |-> !busy)
		else $error("multiplier started while busy");

endmodule

// ==== hw/seq_divider.sv ====
// Sequential divider: restoring division over magnitudes with sign and divide-by-zero fix-ups
`timescale 1ns/1ps
`include "alu_cfg.svh"

module seq_divider import muldiv_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    start,
	input  md_req_t req,
	output logic    busy,
	output logic    done,
	output hilo_t   result
);

	localparam int CNT_W = $clog2(`MULDIV_STEPS);

	logic [`ALU_XLEN-1:0] mag_a;
	logic [`ALU_XLEN-1:0] mag_b;
	logic [`ALU_XLEN-1:0] dsor;		// Divisor magnitude
	logic [`ALU_XLEN-1:0] dvnd_raw;		// Dividend as issued
	logic [`ALU_XLEN-1:0] rem;
	logic [`ALU_XLEN-1:0] quo;		// Dividend bits shift out, quotient bits shift in
	logic                 q_neg;
	logic                 r_neg;
	logic                 div_zero;
	logic [CNT_W-1:0]     step_cnt;
	logic                 last_step;
	logic [`ALU_XLEN:0]   rem_sh;
	logic [`ALU_XLEN+1:0] trial;		// Trial subtraction with borrow bit
	logic                 fits;
	logic [`ALU_XLEN-1:0] rem_next;
	logic [`ALU_XLEN-1:0] quo_next;

	assign mag_a = (req.is_signed && req.a[`ALU_XLEN-1]) ? -req.a : req.a;
	assign mag_b = (req.is_signed && req.b[`ALU_XLEN-1]) ? -req.b : req.b;

	// Bring down the next dividend bit and try the subtraction
	assign rem_sh   = {rem, quo[`ALU_XLEN-1]};
	assign trial    = {1'b0, rem_sh} - {2'b00, dsor};
	assign fits     = !trial[`ALU_XLEN+1];
	assign rem_next = fits ? trial[`ALU_XLEN-1:0] : rem_sh[`ALU_XLEN-1:0];	// Restore on borrow
	assign quo_next = {quo[`ALU_XLEN-2:0], fits};

	assign last_step = (step_cnt == CNT_W'(`MULDIV_STEPS - 1));
	assign done      = busy && last_step;

	// Remainder follows the dividend sign, quotient truncates toward zero
	always_comb begin
		if (div_zero) begin
			result.hi = dvnd_raw;
			result.lo = '1;
		end else begin
			result.hi = r_neg ? -rem_next : rem_next;
			result.lo = q_neg ? -quo_next : quo_next;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			step_cnt <= '0;
		end else if (start) begin
			busy     <= 1'b1;
			step_cnt <= '0;
		end else if (busy) begin
			step_cnt <= step_cnt + 1'b1;
			if (last_step) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			dsor     <= mag_b;
			dvnd_raw <= req.a;
			rem      <= '0;
			quo      <= mag_a;
			q_neg    <= req.is_signed && (req.a[`ALU_XLEN-1] ^ req.b[`ALU_XLEN-1]);
			r_neg    <= req.is_signed && req.a[`ALU_XLEN-1];
			div_zero <= (req.b == '0);	// Still runs the full step count
		end else if (busy) begin
			rem <= rem_next;
			quo <= quo_next;
		end
	end

	// The issuer must wait for stall to drop before the next divide
	a_no_start_while_busy: assert property (@(posedge clk) disable iff (rst)
		start |-> !busy)
		else $error("divider started while busy");

endmodule

// ==== hw/alu_core.sv ====
// ALU core with opcode decode, combinational datapath, HI/LO register and multiply/divide control
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_core import alu_op_pkg::*, muldiv_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     op_valid,
	input  alu_req_t req,
	output alu_res_t res,
	output hilo_t    hilo,
	output logic     stall,
	output logic     mul_start,
	output logic     div_start,
	output md_req_t  md_req,
	input  logic     mul_busy,
	input  logic     mul_done,
	input  logic     div_busy,
	input  logic     div_done,
	input  hilo_t    mul_result,
	input  hilo_t    div_result
);

	logic [4:0]           shamt;
	logic [`ALU_XLEN-1:0] sum;
	logic [`ALU_XLEN-1:0] diff;
	logic                 add_ovf;
	logic                 sub_ovf;
	logic                 slt_bit;
	logic                 sltu_bit;
	logic                 is_mul;
	logic                 is_div;
	logic                 md_signed;
	logic                 touches_hilo;	// Ops that must wait out a stall
	hilo_t                hilo_q;

	assign shamt = req.a[4:0];
	assign sum   = req.a + req.b;
	assign diff  = req.a - req.b;

	// Overflow when the result sign disagrees with what the operand signs allow
	assign add_ovf = (req.a[`ALU_XLEN-1] == req.b[`ALU_XLEN-1]) &&
		(sum[`ALU_XLEN-1] != req.a[`ALU_XLEN-1]);
	assign sub_ovf = (req.a[`ALU_XLEN-1] != req.b[`ALU_XLEN-1]) &&
		(diff[`ALU_XLEN-1] != req.a[`ALU_XLEN-1]);

	assign slt_bit  = $signed(req.a) < $signed(req.b);
	assign sltu_bit = req.a < req.b;

	always_comb begin
		res          = '0;	// No-value ops leave zero
		is_mul       = 1'b0;
		is_div       = 1'b0;
		md_signed    = 1'b0;
		touches_hilo = 1'b0;
		case (req.op)
			op_sll, op_sllv: res.value = req.b << shamt;
			op_srl, op_srlv: res.value = req.b >> shamt;
			op_sra, op_srav: res.value = $unsigned($signed(req.b) >>> shamt);
			op_add: begin
				res.value = sum;
				res.ovf   = add_ovf;
			end
			op_sub: begin
				res.value = diff;
				res.ovf   = sub_ovf;
			end
			op_addu:   res.value = sum;
			op_subu:   res.value = diff;
			op_and:    res.value = req.a & req.b;
			op_or:     res.value = req.a | req.b;
			op_xor:    res.value = req.a ^ req.b;
			op_nor:    res.value = ~(req.a | req.b);
			op_slt:    res.value = {{(`ALU_XLEN-1){1'b0}}, slt_bit};
			op_sltu:   res.value = {{(`ALU_XLEN-1){1'b0}}, sltu_bit};
			op_lui:    res.value = req.b << 16;
			op_pass_a: res.value = req.a;
			op_pass_b: res.value = req.b;
			op_mfhi: begin
				res.value    = hilo_q.hi;
				touches_hilo = 1'b1;
			end
			op_mflo: begin
				res.value    = hilo_q.lo;
				touches_hilo = 1'b1;
			end
			op_mthi, op_mtlo: touches_hilo = 1'b1;
			op_mult, op_multu: begin
				is_mul       = 1'b1;
				md_signed    = (req.op == op_mult);
				touches_hilo = 1'b1;
			end
			op_div, op_divu: begin
				is_div       = 1'b1;
				md_signed    = (req.op == op_div);
				touches_hilo = 1'b1;
			end
			default: ;	// Unknown opcode gives zero
		endcase
	end

	assign mul_start = op_valid && is_mul;
	assign div_start = op_valid && is_div;
	assign md_req    = '{a: req.a, b: req.b, is_signed: md_signed};
	assign stall     = mul_busy || div_busy;
	assign hilo      = hilo_q;

	// Unit results land on done and MTHI/MTLO write one half
	always_ff @(posedge clk) begin
		if (rst) begin
			hilo_q <= '0;
		end else if (mul_done) begin
			hilo_q <= mul_result;
		end else if (div_done) begin
			hilo_q <= div_result;
		end else if (op_valid && req.op == op_mthi) begin
			hilo_q.hi <= req.a;
		end else if (op_valid && req.op == op_mtlo) begin
			hilo_q.lo <= req.a;
		end
	end

	a_no_hilo_op_in_stall: assert property (@(posedge clk) disable iff (rst)
		op_valid && touches_hilo |-> !stall)
		else $error("HI/LO operation issued during stall");

	// A landing result must come from the only running unit
	a_done_exclusive: assert property (@(posedge clk) disable iff (rst)
		(mul_done || div_done) |-> !(mul_busy && div_busy))
		else $error("multiplier and divider both busy when a result landed");

endmodule

// ==== hw/mips_alu.sv ====
// MIPS execute block top: ALU core with its sequential multiplier and divider
`timescale 1ns/1ps

module mips_alu import alu_op_pkg::*, muldiv_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     op_valid,
	input  alu_req_t req,
	output alu_res_t res,
	output hilo_t    hilo,
	output logic     stall
);

	logic    mul_start;
	logic    div_start;
	md_req_t md_req;	// Shared by both units
	logic    mul_busy;
	logic    mul_done;
	logic    div_busy;
	logic    div_done;
	hilo_t   mul_result;
	hilo_t   div_result;

	alu_core i_core (
		.clk        (clk),
		.rst        (rst),
		.op_valid   (op_valid),
		.req        (req),
		.res        (res),
		.hilo       (hilo),
		.stall      (stall),
		.mul_start  (mul_start),
		.div_start  (div_start),
		.md_req     (md_req),
		.mul_busy   (mul_busy),
		.mul_done   (mul_done),
		.div_busy   (div_busy),
		.div_done   (div_done),
		.mul_result (mul_result),
		.div_result (div_result)
	);

	seq_multiplier i_mul (
		.clk    (clk),
		.rst    (rst),
		.start  (mul_start),
		.req    (md_req),
		.busy   (mul_busy),
		.done   (mul_done),
		.result (mul_result)
	);

	seq_divider i_div (
		.clk    (clk),
		.rst    (rst),
		.start  (div_start),
		.req    (md_req),
		.busy   (div_busy),
		.done   (div_done),
		.result (div_result)
	);

endmodule

// ==== dv/tb_clk_gen.sv ====
// Testbench clock and reset source: 8 ns clock, reset held for the first 4 cycles
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 8 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;	// Released just after the fourth edge
	end

endmodule

// ==== dv/tb_mips_alu.sv ====
// Testbench for the MIPS execute block: table of operations checked against a reference model
`timescale 1ns/1ps
`include "alu_cfg.svh"

module tb_mips_alu import alu_op_pkg::*, muldiv_pkg::*; ();

	localparam int STEPS = `MULDIV_STEPS;

	typedef enum {k_comb, k_md, k_hilo, k_bg, k_sync} kind_e;

	typedef struct {
		string    name;
		alu_req_t req;
		alu_res_t exp_res;
		hilo_t    exp_hilo;
		kind_e    kind;
	} entry_t;

	logic        clk;
	logic        rst;
	logic        op_valid;
	alu_req_t    req;
	alu_res_t    res;
	hilo_t       hilo;
	logic        stall;
	entry_t      table_q[$];
	hilo_t       model_hilo;	// HI/LO as the table expects it after each entry
	logic [31:0] rng_state;
	bit          table_ready = 1'b0;
	bit          bg_active;		// A divide runs in the background
	alu_op_e     comb_ops [0:18] = '{op_sll, op_srl, op_sra, op_sllv, op_srlv, op_srav,
		op_add, op_addu, op_sub, op_subu, op_and, op_or, op_xor, op_nor, op_slt, op_sltu,
		op_lui, op_pass_a, op_pass_b};

	tb_clk_gen i_clk_gen (
		.clk (clk),
		.rst (rst)
	);

	mips_alu i_dut (
		.clk      (clk),
		.rst      (rst),
		.op_valid (op_valid),
		.req      (req),
		.res      (res),
		.hilo     (hilo),
		.stall    (stall)
	);

	function automatic logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Quotient truncates toward zero, remainder takes the dividend sign
	function automatic hilo_t ref_div(input logic [31:0] a, input logic [31:0] b, input bit sgn);
		hilo_t h;
		int    sa;
		int    sb;
		if (b == 32'h0) begin
			h.hi = a;
			h.lo = '1;
		end else if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
			h.hi = '0;
			h.lo = a;
		end else if (sgn) begin
			sa = $signed(a);
			sb = $signed(b);
			h.lo = sa / sb;
			h.hi = sa % sb;
		end else begin
			h.lo = a / b;
			h.hi = a % b;
		end
		return h;
	endfunction

	function automatic void ref_exec(input alu_req_t r, input hilo_t h_in,
		output alu_res_t o, output hilo_t h_out);
		logic [4:0]  sh;
		logic [32:0] wide;	// Sign-extended sum or difference
		longint      sa;
		longint      sb;
		sh    = r.a[4:0];
		o     = '0;
		h_out = h_in;
		case (r.op)
			op_sll, op_sllv: o.value = r.b << sh;
			op_srl, op_srlv: o.value = r.b >> sh;
			op_sra, op_srav: o.value = $signed(r.b) >>> sh;
			op_add, op_addu: begin
				wide    = {r.a[31], r.a} + {r.b[31], r.b};
				o.value = wide[31:0];
				o.ovf   = (r.op == op_add) && (wide[32] != wide[31]);
			end
			op_sub, op_subu: begin
				wide    = {r.a[31], r.a} - {r.b[31], r.b};
				o.value = wide[31:0];
				o.ovf   = (r.op == op_sub) && (wide[32] != wide[31]);
			end
			op_and:    o.value = r.a & r.b;
			op_or:     o.value = r.a | r.b;
			op_xor:    o.value = r.a ^ r.b;
			op_nor:    o.value = ~(r.a | r.b);
			op_slt:    o.value = {31'b0, $signed(r.a) < $signed(r.b)};
			op_sltu:   o.value = {31'b0, r.a < r.b};
			op_lui:    o.value = {r.b[15:0], 16'h0};
			op_pass_a: o.value = r.a;
			op_pass_b: o.value = r.b;
			op_mfhi:   o.value = h_in.hi;
			op_mflo:   o.value = h_in.lo;
			op_mthi:   h_out.hi = r.a;
			op_mtlo:   h_out.lo = r.a;
			op_mult: begin
				sa    = longint'($signed(r.a));
				sb    = longint'($signed(r.b));
				h_out = hilo_t'(sa * sb);
			end
			op_multu:        h_out = hilo_t'({32'h0, r.a} * {32'h0, r.b});
			op_div, op_divu: h_out = ref_div(r.a, r.b, r.op == op_div);
			default: ;
		endcase
	endfunction

	function automatic void push_op(input string name, input alu_op_e op,
		input logic [31:0] a, input logic [31:0] b, input kind_e kind);
		entry_t e;
		e.name = name;
		e.req  = '{op: op, a: a, b: b};
		e.kind = kind;
		if (kind == k_sync) begin
			e.exp_res = '0;	// Nothing issued, only HI/LO is checked
		end else begin
			ref_exec(e.req, model_hilo, e.exp_res, model_hilo);
		end
		e.exp_hilo = model_hilo;
		table_q.push_back(e);
	endfunction

	task automatic build_table();
		int          i;
		int          idx;
		logic [31:0] a;
		logic [31:0] b;
		alu_op_e     md_ops [0:3] = '{op_mult, op_multu, op_div, op_divu};
		push_op("sll_by0", op_sll, 32'd0, 32'h8000_0001, k_comb);
		push_op("sll_by31", op_sll, 32'd31, 32'h0000_0003, k_comb);
		push_op("srl_by31", op_srl, 32'd31, 32'h8000_0000, k_comb);
		push_op("sra_neg", op_sra, 32'd4, 32'h8000_0000, k_comb);
		push_op("sra_by31", op_sra, 32'd31, 32'h8000_0000, k_comb);
		push_op("sllv_upper_a", op_sllv, 32'hffff_ffe4, 32'h0000_0001, k_comb);
		push_op("srlv", op_srlv, 32'd8, 32'hff00_0000, k_comb);
		push_op("srav_neg", op_srav, 32'h0000_0021, 32'hf000_0000, k_comb);
		push_op("add_ovf_pos", op_add, 32'h7fff_ffff, 32'h0000_0001, k_comb);
		push_op("add_ovf_neg", op_add, 32'h8000_0000, 32'h8000_0000, k_comb);
		push_op("add_wrap_ok", op_add, 32'hffff_ffff, 32'h0000_0001, k_comb);
		push_op("addu_no_ovf", op_addu, 32'h7fff_ffff, 32'h0000_0001, k_comb);
		push_op("sub_ovf_neg", op_sub, 32'h8000_0000, 32'h0000_0001, k_comb);
		push_op("sub_ovf_pos", op_sub, 32'h7fff_ffff, 32'hffff_ffff, k_comb);
		push_op("subu_no_ovf", op_subu, 32'h8000_0000, 32'h0000_0001, k_comb);
		push_op("and", op_and, 32'hf0f0_1234, 32'h0ff0_ffff, k_comb);
		push_op("or", op_or, 32'hf0f0_0000, 32'h0f0f_0001, k_comb);
		push_op("xor", op_xor, 32'haaaa_5555, 32'hffff_0000, k_comb);
		push_op("nor", op_nor, 32'hf0f0_0000, 32'h0000_000f, k_comb);
		push_op("slt_mixed", op_slt, 32'hffff_ffff, 32'h0000_0001, k_comb);
		push_op("sltu_mixed", op_sltu, 32'hffff_ffff, 32'h0000_0001, k_comb);
		push_op("slt_equal", op_slt, 32'h8000_0000, 32'h8000_0000, k_comb);
		push_op("lui", op_lui, 32'h0, 32'habcd_1234, k_comb);
		push_op("pass_a", op_pass_a, 32'hcafe_f00d, 32'h1, k_comb);
		push_op("pass_b", op_pass_b, 32'h1, 32'h1357_9bdf, k_comb);
		push_op("mthi", op_mthi, 32'hdead_beef, 32'h0, k_hilo);
		push_op("mtlo", op_mtlo, 32'h0123_4567, 32'h0, k_hilo);
		push_op("mfhi_written", op_mfhi, 32'h0, 32'h0, k_comb);
		push_op("mflo_written", op_mflo, 32'h0, 32'h0, k_comb);
		push_op("mult_neg_pos", op_mult, 32'hffff_fffd, 32'd7, k_md);
		push_op("mult_min_min", op_mult, 32'h8000_0000, 32'h8000_0000, k_md);
		push_op("multu_max", op_multu, 32'hffff_ffff, 32'hffff_ffff, k_md);
		push_op("mfhi_product", op_mfhi, 32'h0, 32'h0, k_comb);
		push_op("mflo_product", op_mflo, 32'h0, 32'h0, k_comb);
		push_op("div_pos", op_div, 32'd100, 32'd7, k_md);
		push_op("div_neg_dividend", op_div, 32'hffff_ff9c, 32'd7, k_md);
		push_op("div_neg_divisor", op_div, 32'd100, 32'hffff_fff9, k_md);
		push_op("divu_large", op_divu, 32'hffff_ffff, 32'd10, k_md);
		push_op("div_by_zero", op_div, 32'hffff_fffb, 32'h0, k_md);
		push_op("divu_by_zero", op_divu, 32'h1234_5678, 32'h0, k_md);
		push_op("div_min_by_m1", op_div, 32'h8000_0000, 32'hffff_ffff, k_md);
		push_op("mfhi_quotient", op_mfhi, 32'h0, 32'h0, k_comb);
		push_op("mflo_quotient", op_mflo, 32'h0, 32'h0, k_comb);
		// Combinational traffic while a divide is still running
		push_op("div_background", op_div, 32'h7fff_ffff, 32'd3, k_bg);
		for (i = 0; i < 8; i++) begin
			idx = int'(xorshift32() % 32'd19);
			a   = xorshift32();
			b   = xorshift32();
			push_op($sformatf("bg_%s_%0d", comb_ops[idx].name(), i), comb_ops[idx], a, b, k_comb);
		end
		push_op("div_background_result", op_sll, 32'h0, 32'h0, k_sync);
		for (i = 0; i < 24; i++) begin
			idx = int'(xorshift32() % 32'd19);
			a   = xorshift32();
			b   = xorshift32();
			push_op($sformatf("rand_%s_%0d", comb_ops[idx].name(), i), comb_ops[idx], a, b, k_comb);
		end
		for (i = 0; i < 12; i++) begin
			a = xorshift32();
			b = xorshift32() >> (i * 2);	// Divisors from large down to small
			push_op($sformatf("rand_%s_%0d", md_ops[i % 4].name(), i), md_ops[i % 4], a, b, k_md);
			push_op($sformatf("rand_mfhi_%0d", i), op_mfhi, 32'h0, 32'h0, k_comb);
		end
	endtask

	task automatic report_fail(input string line);
		$display("%s", line);
		$display("test failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_res(input string name, input alu_res_t exp_v, input alu_res_t act);
		if (act !== exp_v) begin
			report_fail($sformatf("CHECK FAILED %s res expected value=%h ovf=%b actual value=%h ovf=%b",
				name, exp_v.value, exp_v.ovf, act.value, act.ovf));
		end
	endtask

	task automatic check_hilo(input string name, input hilo_t exp_v, input hilo_t act);
		if (act !== exp_v) begin
			report_fail($sformatf("CHECK FAILED %s hilo expected hi=%h lo=%h actual hi=%h lo=%h",
				name, exp_v.hi, exp_v.lo, act.hi, act.lo));
		end
	endtask

	task automatic check_stall(input string name, input logic exp_v, input logic act);
		if (act !== exp_v) begin
			report_fail($sformatf("CHECK FAILED %s stall expected %b actual %b", name, exp_v, act));
		end
	endtask

	// Inputs change 1 ns after the edge, outputs are sampled 3 ns after it
	task automatic run_entry(input entry_t e);
		int i;
		if (e.kind == k_sync) begin
			#2;
			while (stall !== 1'b0) begin
				@(posedge clk);
				#3;
			end
			check_hilo(e.name, e.exp_hilo, hilo);
			bg_active = 1'b0;
		end else begin
			@(posedge clk);
			#1;
			op_valid = 1'b1;
			req      = e.req;
			#2;
			check_res(e.name, e.exp_res, res);
			if (bg_active) begin
				check_stall(e.name, 1'b1, stall);
			end
			@(posedge clk);
			#1;
			op_valid = 1'b0;
			case (e.kind)
				k_hilo: begin
					#2;
					check_hilo(e.name, e.exp_hilo, hilo);
				end
				k_md: begin
					for (i = 0; i < STEPS; i++) begin	// Busy for exactly STEPS cycles
						#2;
						check_stall(e.name, 1'b1, stall);
						@(posedge clk);
						#1;
					end
					#2;
					check_stall(e.name, 1'b0, stall);
					check_hilo(e.name, e.exp_hilo, hilo);
				end
				k_bg: bg_active = 1'b1;
				default: ;
			endcase
		end
	endtask

	initial begin : watchdog
		wait (table_ready);
		repeat (table_q.size() * (STEPS + 8) + 8) @(posedge clk);
		report_fail("watchdog expired, the run hung before all table entries were applied");
	end

	initial begin
		op_valid   = 1'b0;
		req        = '0;
		bg_active  = 1'b0;
		model_hilo = '0;
		rng_state  = 32'd13;
		build_table();
		table_ready = 1'b1;
		wait (rst === 1'b0);
		@(posedge clk);
		#3;
		check_stall("after_reset", 1'b0, stall);
		check_hilo("after_reset", '0, hilo);
		foreach (table_q[i]) begin
			run_entry(table_q[i]);
		end
		$display("test passed");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+hw
hw/alu_op_pkg.sv
hw/muldiv_pkg.sv
hw/seq_multiplier.sv
hw/seq_divider.sv
hw/alu_core.sv
hw/mips_alu.sv
dv/tb_clk_gen.sv
dv/tb_mips_alu.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module tb_mips_alu -o sim_tb &&
./obj_dir/sim_tb || exit 1
